/* logic/address_translate.sv */
// two-stage address translation
// stage 0 decodes the region of the incoming address, stage 1 adds the
// matching per-thread offset and registers the result

`timescale 1ns/1ps

module address_translate #(
    parameter addressing_pkg::addr_t io_base       = 12'h100,
    parameter addressing_pkg::addr_t io_size       = 12'h040,
    parameter addressing_pkg::addr_t high_mem_base = 12'hC00,
    parameter addressing_pkg::addr_t ind_base      = 12'h800,
    parameter addressing_pkg::addr_t ind_size      = 12'h100
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     addr_valid_in,
    input  addressing_pkg::addr_t    addr_in,
    input  addressing_pkg::thread_t  write_thread,
    input  addressing_pkg::addr_t    default_offset,
    input  addressing_pkg::addr_t    programmed_offset,
    output logic                     advance,
    output logic                     addr_valid,
    output addressing_pkg::addr_t    addr_out,
    output addressing_pkg::thread_t  thread_out
);
    import addressing_pkg::*;

    region_t region;
    access_t stage1;
    addr_t   offset_sel;

    // ------------------------------------------------------------------------
    // stage 0 region decode
    // ------------------------------------------------------------------------

    // window tests subtract the base first so a window near the top
    // of the address space does not overflow
    always_comb begin
        if (addr_t'(addr_in - io_base) < io_size) begin
            region = region_io;
        end else if (addr_in >= high_mem_base) begin
            region = region_high_mem;
        end else if (addr_t'(addr_in - ind_base) < ind_size) begin
            region = region_indirect;
        end else begin
            region = region_private;
        end
    end

    always_ff @(posedge clock) begin
        stage1.addr   <= addr_in;
        stage1.region <= region;
        if (reset) begin
            stage1.valid <= 1'b0;
        end else begin
            stage1.valid <= addr_valid_in;
        end
    end

    // ------------------------------------------------------------------------
    // stage 1 offset select and add
    // ------------------------------------------------------------------------

    always_comb begin
        case (stage1.region)
            region_io, region_high_mem: offset_sel = default_offset;
            region_indirect:            offset_sel = programmed_offset;
            default:                    offset_sel = '0;
        endcase
    end

    // tells the offset unit to step this thread's programmed offset
    assign advance = stage1.valid && (stage1.region == region_indirect);

    always_ff @(posedge clock) begin
        addr_out   <= stage1.addr + offset_sel;
        thread_out <= write_thread;
        if (reset) begin
            addr_valid <= 1'b0;
        end else begin
            addr_valid <= stage1.valid;
        end
    end

endmodule

/* logic/addressing.sv */
// per-thread address translation, top level
// adds a thread's default or programmed offset to shared-code addresses
// configure the tables through cfg_write and the three write enables

`timescale 1ns/1ps

module addressing #(
    parameter int                    thread_count  = 8,
    parameter addressing_pkg::addr_t io_base       = 12'h100,
    parameter addressing_pkg::addr_t io_size       = 12'h040,
    parameter addressing_pkg::addr_t high_mem_base = 12'hC00,
    parameter addressing_pkg::addr_t ind_base      = 12'h800,
    parameter addressing_pkg::addr_t ind_size      = 12'h100
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        addr_valid_in,
    input  addressing_pkg::addr_t       addr_in,
    input  logic                        default_offset_wren,
    input  logic                        increment_wren,
    input  logic                        programmed_offset_wren,
    input  addressing_pkg::cfg_write_t  cfg_write,
    output logic                        addr_valid,
    output addressing_pkg::addr_t       addr_out,
    output addressing_pkg::thread_t     thread_out
);
    import addressing_pkg::*;

    thread_t read_thread;
    thread_t write_thread;
    addr_t   default_offset;
    incr_t   increment;
    addr_t   prog_offset;
    logic    advance;

    // ------------------------------------------------------------------------
    // thread sequencing and per-thread tables
    // ------------------------------------------------------------------------

    thread_number #(
        .thread_count (thread_count)
    ) thread_number_i (
        .clock        (clock),
        .reset        (reset),
        .read_thread  (read_thread),
        .write_thread (write_thread)
    );

    thread_table #(
        .payload_t    (addr_t),
        .thread_count (thread_count)
    ) default_offsets (
        .clock       (clock),
        .reset       (reset),
        .wren        (default_offset_wren),
        .cfg_write   (cfg_write),
        .read_thread (read_thread),
        .read_data   (default_offset)
    );

    thread_table #(
        .payload_t    (incr_t),
        .thread_count (thread_count)
    ) increments (
        .clock       (clock),
        .reset       (reset),
        .wren        (increment_wren),
        .cfg_write   (cfg_write),
        .read_thread (read_thread),
        .read_data   (increment)
    );

    programmed_offset #(
        .thread_count (thread_count)
    ) programmed_offset_i (
        .clock        (clock),
        .reset        (reset),
        .wren         (programmed_offset_wren),
        .cfg_write    (cfg_write),
        .read_thread  (read_thread),
        .write_thread (write_thread),
        .increment    (increment),
        .advance      (advance),
        .offset       (prog_offset)
    );

    // ------------------------------------------------------------------------
    // translation pipeline
    // ------------------------------------------------------------------------

    address_translate #(
        .io_base       (io_base),
        .io_size       (io_size),
        .high_mem_base (high_mem_base),
        .ind_base      (ind_base),
        .ind_size      (ind_size)
    ) address_translate_i (
        .clock             (clock),
        .reset             (reset),
        .addr_valid_in     (addr_valid_in),
        .addr_in           (addr_in),
        .write_thread      (write_thread),
        .default_offset    (default_offset),
        .programmed_offset (prog_offset),
        .advance           (advance),
        .addr_valid        (addr_valid),
        .addr_out          (addr_out),
        .thread_out        (thread_out)
    );

endmodule

/* logic/addressing_pkg.sv */
// shared widths and types for the per-thread address translation block
// every RTL module refers to these through addressing_pkg

package addressing_pkg;

    parameter int addr_width   = 12;
    parameter int thread_width = 3;
    parameter int incr_width   = 4;

    typedef logic [addr_width-1:0]   addr_t;
    typedef logic [thread_width-1:0] thread_t;
    typedef logic [incr_width-1:0]   incr_t;

    // private addresses pass through untouched and the others take an offset
    typedef enum logic [1:0] {
        region_private,
        region_io,
        region_high_mem,
        region_indirect
    } region_t;

    // all three per-thread tables share one configuration write
    typedef struct packed {
        thread_t thread;
        addr_t   data;
    } cfg_write_t;

    // a decoded access as it moves from stage 0 to stage 1
    typedef struct packed {
        addr_t   addr;
        region_t region;
        logic    valid;
    } access_t;

endpackage

/* logic/programmed_offset.sv */
// per-thread programmed offsets for the indirect window
// each indirect access steps the thread's offset by its increment
// so the next turn of that thread sees the next element

`timescale 1ns/1ps

module programmed_offset #(
    parameter int thread_count = 8
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        wren,
    input  addressing_pkg::cfg_write_t  cfg_write,
    input  addressing_pkg::thread_t     read_thread,
    input  addressing_pkg::thread_t     write_thread,
    input  addressing_pkg::incr_t       increment,
    input  logic                        advance,
    output addressing_pkg::addr_t       offset
);
    import addressing_pkg::*;

    addr_t offsets [thread_count];
    addr_t step;
    addr_t next_offset;

    // ------------------------------------------------------------------------
    // post-increment value
    // ------------------------------------------------------------------------

    // the increment is unsigned, so it is zero-extended before the add
    assign step        = {{(addr_width - incr_width){1'b0}}, increment};
    assign next_offset = offset + step;

    // ------------------------------------------------------------------------
    // storage with registered read
    // ------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < thread_count; i++) begin
                offsets[i] <= '0;
            end
            offset <= '0;
        end else begin
            // offset holds the value that stage 1 just used for write_thread
            if (advance) begin
                offsets[write_thread] <= next_offset;
            end
            // a configuration write to the same thread overrides the step
            if (wren && (cfg_write.thread < thread_count)) begin
                offsets[cfg_write.thread] <= cfg_write.data;
            end
            offset <= offsets[read_thread];
        end
    end

endmodule

/* logic/thread_number.sv */
// round-robin thread counter for the two-stage translation pipeline
// read_thread owns stage 0 and write_thread is the thread now in stage 1

`timescale 1ns/1ps

module thread_number #(
    parameter int thread_count = 8
) (
    input  logic                     clock,
    input  logic                     reset,
    output addressing_pkg::thread_t  read_thread,
    output addressing_pkg::thread_t  write_thread
);
    import addressing_pkg::*;

    localparam thread_t last_thread = thread_t'(thread_count - 1);

    always_ff @(posedge clock) begin
        if (reset) begin
            read_thread  <= '0;
            // stage 1 trails stage 0 by one slot, so it starts on the last thread
            write_thread <= last_thread;
        end else begin
            read_thread  <= (read_thread == last_thread) ? '0 : read_thread + 1'b1;
            write_thread <= read_thread;
        end
    end

endmodule

/* logic/thread_table.sv */
// one payload per thread, loaded by configuration writes
// the read is registered, so data for read_thread shows up the next cycle
// used for both the default offsets and the increments

`timescale 1ns/1ps

module thread_table #(
    parameter type payload_t    = addressing_pkg::addr_t,
    parameter int  thread_count = 8
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        wren,
    input  addressing_pkg::cfg_write_t  cfg_write,
    input  addressing_pkg::thread_t     read_thread,
    output payload_t                    read_data
);

    payload_t entries [thread_count];
    payload_t write_payload;

    // narrow payloads take the low bits of the write data
    assign write_payload = cfg_write.data[$bits(payload_t)-1:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < thread_count; i++) begin
                entries[i] <= '0;
            end
            read_data <= '0;
        end else begin
            // writes to a thread number beyond thread_count are dropped
            if (wren && (cfg_write.thread < thread_count)) begin
                entries[cfg_write.thread] <= write_payload;
            end
            read_data <= entries[read_thread];
        end
    end

endmodule

/* verification/addressing_asserts.sv */
// concurrent checks on the output strobe and thread order of the translation block
// bound into every addressing instance by the bind at the bottom of this file

`timescale 1ns/1ps

module addressing_asserts #(
    parameter int thread_count = 8
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     addr_valid_in,
    input  logic                     addr_valid,
    input  addressing_pkg::thread_t  thread_out
);
    import addressing_pkg::*;

    int failures = 0;

    function automatic thread_t following(input thread_t thread);
        return (thread == thread_t'(thread_count - 1)) ? '0 : thread + 1'b1;
    endfunction

    // every access leaves the pipeline exactly two clocks after it enters
    valid_latency: assert property (@(posedge clock) disable iff (reset)
        addr_valid == $past(addr_valid_in, 2))
    else begin
        failures++;
        $error("addr_valid does not follow addr_valid_in by two clocks");
    end

    reset_quiet: assert property (@(posedge clock) $past(reset) |-> !addr_valid)
    else begin
        failures++;
        $error("addr_valid is high while reset is applied");
    end

    // outputs on back-to-back cycles belong to consecutive threads
    thread_order: assert property (@(posedge clock) disable iff (reset)
        (addr_valid && $past(addr_valid)) |-> (thread_out == following($past(thread_out))))
    else begin
        failures++;
        $error("thread_out did not step to the next thread");
    end

endmodule

bind addressing addressing_asserts #(
    .thread_count (thread_count)
) asserts_i (
    .clock         (clock),
    .reset         (reset),
    .addr_valid_in (addr_valid_in),
    .addr_valid    (addr_valid),
    .thread_out    (thread_out)
);

/* verification/addressing_tb.sv */
// testbench for the per-thread address translation block
// replays the records of addressing_testdata.hex and runs from the project root

`timescale 1ns/1ps

module addressing_tb;
    import addressing_pkg::*;

    localparam int thread_count = 8;
    localparam int max_records  = 64;

    logic       clock;
    logic       reset;
    logic       addr_valid_in;
    addr_t      addr_in;
    logic       default_offset_wren;
    logic       increment_wren;
    logic       programmed_offset_wren;
    cfg_write_t cfg_write;
    logic       addr_valid;
    addr_t      addr_out;
    thread_t    thread_out;

    logic [31:0] records [max_records];
    int          record_count;
    int          cycle_limit = 1000;
    int          cycle_count = 0;
    int          addr_errors = 0;
    int          thread_errors = 0;
    int          valid_errors = 0;
    int          setup_errors = 0;
    thread_t     slot_thread;
    logic [31:0] lcg_state = 32'h3eef;

    // expected results of the two accesses in flight where index 1 is the older one
    logic    pipe_valid [2];
    addr_t   pipe_addr [2];
    thread_t pipe_thread [2];
    int      pipe_record [2];

    addressing #(
        .thread_count (thread_count)
    ) dut_i (
        .clock                  (clock),
        .reset                  (reset),
        .addr_valid_in          (addr_valid_in),
        .addr_in                (addr_in),
        .default_offset_wren    (default_offset_wren),
        .increment_wren         (increment_wren),
        .programmed_offset_wren (programmed_offset_wren),
        .cfg_write              (cfg_write),
        .addr_valid             (addr_valid),
        .addr_out               (addr_out),
        .thread_out             (thread_out)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic thread_t next_thread(input thread_t thread);
        return (thread == thread_t'(thread_count - 1)) ? '0 : thread + 1'b1;
    endfunction

    task automatic check_addr(input addr_t actual, input addr_t expected, input int index);
        if (actual !== expected) begin
            addr_errors++;
            $display("CHECK FAILED at %0t: record %0d addr_out is %h, expected %h",
                     $time, index, actual, expected);
        end
    endtask

    task automatic check_thread(input thread_t actual, input thread_t expected, input int index);
        if (actual !== expected) begin
            thread_errors++;
            $display("CHECK FAILED at %0t: record %0d thread_out is %0d, expected %0d",
                     $time, index, actual, expected);
        end
    endtask

    task automatic check_valid(input logic actual, input logic expected);
        if (actual !== expected) begin
            valid_errors++;
            $display("CHECK FAILED at %0t: addr_valid is %b, expected %b",
                     $time, actual, expected);
        end
    endtask

    // moves to the next falling edge, checks the access driven two slots
    // ago and returns all strobes to idle
    task automatic next_slot();
        @(negedge clock);
        slot_thread = next_thread(slot_thread);
        check_valid(addr_valid, pipe_valid[1]);
        if (pipe_valid[1]) begin
            check_addr(addr_out, pipe_addr[1], pipe_record[1]);
            check_thread(thread_out, pipe_thread[1], pipe_record[1]);
        end
        pipe_valid[1]          = pipe_valid[0];
        pipe_addr[1]           = pipe_addr[0];
        pipe_thread[1]         = pipe_thread[0];
        pipe_record[1]         = pipe_record[0];
        pipe_valid[0]          = 1'b0;
        addr_valid_in          = 1'b0;
        default_offset_wren    = 1'b0;
        increment_wren         = 1'b0;
        programmed_offset_wren = 1'b0;
    endtask

    task automatic configure(input logic [3:0] kind, input thread_t thread, input addr_t value);
        next_slot();
        cfg_write.thread = thread;
        cfg_write.data   = value;
        case (kind)
            4'd1:    default_offset_wren = 1'b1;
            4'd2:    increment_wren = 1'b1;
            default: programmed_offset_wren = 1'b1;
        endcase
    endtask

    task automatic run_access(input int index, input thread_t thread, input addr_t addr,
                              input addr_t expected);
        next_slot();
        // a thread that is not already up may have to wait one extra rotation
        if (slot_thread != thread) begin
            lcg_state = lcg_next(lcg_state);
            if (lcg_state[31:30] == 2'b00) begin
                repeat (thread_count) next_slot();
            end
        end
        while (slot_thread != thread) begin
            next_slot();
        end
        addr_valid_in  = 1'b1;
        addr_in        = addr;
        pipe_valid[0]  = 1'b1;
        pipe_addr[0]   = expected;
        pipe_thread[0] = thread;
        pipe_record[0] = index;
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [3:0] kind;
        thread_t    thread;
        addr_t      value;
        addr_t      expected;
        int         assert_errors;
        int         total_errors;

        reset                  = 1'b1;
        addr_valid_in          = 1'b0;
        addr_in                = '0;
        default_offset_wren    = 1'b0;
        increment_wren         = 1'b0;
        programmed_offset_wren = 1'b0;
        cfg_write              = '0;
        slot_thread            = '0;
        for (int i = 0; i < 2; i++) begin
            pipe_valid[i]  = 1'b0;
            pipe_addr[i]   = '0;
            pipe_thread[i] = '0;
            pipe_record[i] = 0;
        end

        for (int i = 0; i < max_records; i++) begin
            records[i] = '0;
        end
        $readmemh("verification/addressing_testdata.hex", records);
        record_count = 0;
        while (record_count < max_records && records[record_count][31:28] != 4'd0) begin
            record_count++;
        end
        if (record_count == 0) begin
            $display("no stimulus records were found in the data file");
            setup_errors++;
        end
        cycle_limit = record_count * 2 * thread_count + 100;

        repeat (10) @(posedge clock);
        @(negedge clock);
        reset       = 1'b0;
        slot_thread = '0;

        for (int i = 0; i < record_count; i++) begin
            kind     = records[i][31:28];
            thread   = thread_t'(records[i][27:24]);
            value    = records[i][23:12];
            expected = records[i][11:0];
            if (kind == 4'd4) begin
                run_access(i, thread, value, expected);
            end else begin
                configure(kind, thread, value);
            end
        end

        // drain the pipeline and see addr_valid drop again
        repeat (3) next_slot();

        assert_errors = dut_i.asserts_i.failures;
        total_errors  = addr_errors + thread_errors + valid_errors + setup_errors + assert_errors;
        $display("errors: addr %0d, thread %0d, valid %0d, assertion %0d, setup %0d",
                 addr_errors, thread_errors, valid_errors, assert_errors, setup_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verification/addressing_testdata.hex */
// one record per line as kind_thread_value_expected, 4 + 4 + 12 + 12 bits
// kind 1 default offset, 2 increment, 3 programmed offset, 4 access with expected addr_out
// tables cleared by reset, every region passes unchanged
4_0_050_050
4_1_120_120
4_2_C10_C10
4_3_810_810
4_4_FFF_FFF
// default offsets
1_0_200_000
1_1_300_000
1_2_7F0_000
1_5_123_000
4_0_110_310
4_1_110_410
4_2_13F_92F
4_2_C00_3F0
4_5_FFF_122
4_1_D00_000
4_3_110_110
4_0_140_140
// private addresses ignore the default offset
4_0_050_050
4_1_7FF_7FF
4_2_BFF_BFF
// programmed offsets and increments, upper data bits of 0F4 fall away
3_4_400_000
2_4_003_000
3_6_050_000
2_6_002_000
3_7_FFE_000
2_7_0F4_000
4_4_810_C10
4_4_820_C23
4_4_8FF_D05
4_6_800_850
4_4_800_C09
4_6_800_852
4_5_810_810
4_4_120_120
4_4_800_C0C
4_7_8F0_8EE
4_7_8F0_8F2
// a new programmed offset restarts the sequence
3_4_100_000
4_4_800_900
4_4_801_904
// back-to-back accesses on consecutive threads
4_0_130_330
4_1_810_810
4_2_E00_5F0
4_3_050_050
4_4_810_916
4_5_100_223
4_6_8FF_953
4_7_C00_C00

/* verilog.f */
logic/addressing_pkg.sv
logic/thread_number.sv
logic/thread_table.sv
logic/programmed_offset.sv
logic/address_translate.sv
logic/addressing.sv
verification/addressing_asserts.sv
verification/addressing_tb.sv
